/* include/core_cfg.svh */
////////////////////////////////////////
// core configuration defines
// bridge widths, register hold length and
// video formatter timing constants
////////////////////////////////////////

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

////////////////////////////////////////
// bridge bus
////////////////////////////////////////

// address width of the bridge bus
`define CORE_ADDR_WIDTH 32
// write data width of the bridge bus
`define CORE_DATA_WIDTH 32

////////////////////////////////////////
// settings
////////////////////////////////////////

// reset hold length, short for simulation
`define CORE_RESET_HOLD_CYCLES 64
// depth of the settings register chain
`define CORE_SYNC_STAGES 3

////////////////////////////////////////
// video
////////////////////////////////////////

`define CORE_RGB_WIDTH 24
// hsync delay, keeps hs clear of vs
`define CORE_HS_DELAY 7
// orientation flag position in slot word
`define CORE_SLOT_BIT 13

`endif

/* verilog/core_pkg.sv */
////////////////////////////////////////
// core shared types
// register map, orientation modes and the
// structs carried between the blocks
////////////////////////////////////////

`include "core_cfg.svh"

package core_pkg;

  // bridge register map
  typedef enum logic [`CORE_ADDR_WIDTH-1:0] {
    reg_cart_download   = 32'h0000_0000,
    reg_color_cart      = 32'h0000_0004,
    reg_bw_bios         = 32'h0000_0008,
    reg_color_bios      = 32'h0000_000C,
    reg_save_download   = 32'h0000_0010,
    reg_reset           = 32'h0000_0050,
    reg_system          = 32'h0000_0100,
    reg_turbo           = 32'h0000_0110,
    reg_rewind          = 32'h0000_0114,
    reg_triple_buffer   = 32'h0000_0200,
    reg_flickerblend    = 32'h0000_0204,
    reg_orientation     = 32'h0000_0208,
    reg_flip_h          = 32'h0000_020C,
    reg_ff_sound        = 32'h0000_0300
  } bridge_reg_e;

  // display orientation modes
  typedef enum logic [1:0] {
    orient_auto           = 2'd0,
    orient_horizontal     = 2'd1,
    orient_vertical       = 2'd2,
    orient_alt_horizontal = 2'd3
  } orientation_e;

  // all core settings, msb first
  typedef struct packed {
    logic         external_reset;
    logic         cart_download;
    logic         is_color_cart;
    logic         bw_bios_download;
    logic         color_bios_download;
    logic         save_download;
    logic [1:0]   configured_system;
    logic         use_cpu_turbo;
    logic         use_rewind_capture;
    logic         use_triple_buffer;
    logic [1:0]   configured_flickerblend;
    orientation_e configured_orientation;
    logic         use_flip_horizontal;
    logic         use_fastforward_sound;
  } core_settings_t;

  // video straight from the emulator core
  typedef struct packed {
    logic                       hblank;
    logic                       vblank;
    logic                       hsync;
    logic                       vsync;
    logic [`CORE_RGB_WIDTH-1:0] rgb;
    logic                       is_vertical;
  } core_video_t;

  // video as the scaler expects it
  typedef struct packed {
    logic [`CORE_RGB_WIDTH-1:0] rgb;
    logic                       de;
    logic                       hs;
    logic                       vs;
  } scaler_video_t;

endpackage

/* verilog/bridge_settings_regs.sv */
////////////////////////////////////////
// bridge settings registers
// decodes bridge writes into the core
// settings and runs the reset hold counter
////////////////////////////////////////

`timescale 1ns/1ps

`include "core_cfg.svh"

module bridge_settings_regs (
  input  logic                        clk_74a,
  input  logic                        reset,

  // bridge write port
  input  logic [`CORE_ADDR_WIDTH-1:0] bridge_addr,
  input  logic                        bridge_wr,
  input  logic [`CORE_DATA_WIDTH-1:0] bridge_wr_data,

  // settings before the register chain
  output core_pkg::core_settings_t    raw_settings
);

  // counter wide enough for the full hold value
  localparam int hold_width = $clog2(`CORE_RESET_HOLD_CYCLES + 1);
  localparam logic [hold_width-1:0] hold_load = hold_width'(`CORE_RESET_HOLD_CYCLES);

  // register copy of the settings
  // external_reset field here stays zero, the counter drives it
  core_pkg::core_settings_t cfg_q;

  // reset hold countdown
  logic [hold_width-1:0] hold_cnt;

  ////////////////////////////////////////
  // reset hold counter
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      hold_cnt <= '0;
    end else begin
      // count down while holding
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      // reset write restarts the hold, data ignored
      if (bridge_wr && (bridge_addr == core_pkg::reg_reset)) begin
        hold_cnt <= hold_load;
      end
    end
  end

  ////////////////////////////////////////
  // register decode
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      cfg_q <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        // downloads and cart type
        core_pkg::reg_cart_download: begin
          cfg_q.cart_download <= bridge_wr_data[0];
        end
        core_pkg::reg_color_cart: begin
          cfg_q.is_color_cart <= bridge_wr_data[0];
        end
        core_pkg::reg_bw_bios: begin
          cfg_q.bw_bios_download <= bridge_wr_data[0];
        end
        core_pkg::reg_color_bios: begin
          cfg_q.color_bios_download <= bridge_wr_data[0];
        end
        core_pkg::reg_save_download: begin
          cfg_q.save_download <= bridge_wr_data[0];
        end
        // system and cpu
        core_pkg::reg_system: begin
          cfg_q.configured_system <= bridge_wr_data[1:0];
        end
        core_pkg::reg_turbo: begin
          cfg_q.use_cpu_turbo <= bridge_wr_data[0];
        end
        core_pkg::reg_rewind: begin
          cfg_q.use_rewind_capture <= bridge_wr_data[0];
        end
        // display options
        core_pkg::reg_triple_buffer: begin
          cfg_q.use_triple_buffer <= bridge_wr_data[0];
        end
        core_pkg::reg_flickerblend: begin
          cfg_q.configured_flickerblend <= bridge_wr_data[1:0];
        end
        core_pkg::reg_orientation: begin
          cfg_q.configured_orientation <= core_pkg::orientation_e'(bridge_wr_data[1:0]);
        end
        core_pkg::reg_flip_h: begin
          cfg_q.use_flip_horizontal <= bridge_wr_data[0];
        end
        // sound
        core_pkg::reg_ff_sound: begin
          cfg_q.use_fastforward_sound <= bridge_wr_data[0];
        end
        // reset handled by the counter, unknown addresses dropped
        default: begin
        end
      endcase
    end
  end

  // merge registers with the hold state
  always_comb begin
    raw_settings                = cfg_q;
    raw_settings.external_reset = (hold_cnt != '0);
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // hold never runs past its load value
  a_hold_bounded: assert property (
    @(posedge clk_74a) disable iff (reset)
      hold_cnt <= hold_load
  );

endmodule

/* verilog/settings_sync.sv */
////////////////////////////////////////
// settings register chain
// carries the settings struct through a
// fixed number of register stages
////////////////////////////////////////

`timescale 1ns/1ps

`include "core_cfg.svh"

module settings_sync (
  input  logic                     clk_74a,
  input  logic                     reset,

  // settings from the register decode
  input  core_pkg::core_settings_t raw_settings,

  // settings after the last stage
  output core_pkg::core_settings_t settings
);

  localparam int sync_stages = `CORE_SYNC_STAGES;

  // one struct per stage, stage 0 nearest the input
  core_pkg::core_settings_t stage_q [sync_stages];

  ////////////////////////////////////////
  // register chain
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      for (int i = 0; i < sync_stages; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      // first stage samples the raw value
      stage_q[0] <= raw_settings;
      // the rest shift along
      for (int i = 1; i < sync_stages; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // last stage feeds the core and the video path
  assign settings = stage_q[sync_stages-1];

endmodule

/* verilog/video_output_formatter.sv */
////////////////////////////////////////
// video output formatter
// registers core video for the scaler,
// inserts the orientation slot word and
// shapes hsync and vsync into pulses
////////////////////////////////////////

`timescale 1ns/1ps

`include "core_cfg.svh"

module video_output_formatter (
  input  logic                    clk_74a,
  input  logic                    reset,

  // raw core video
  input  core_pkg::core_video_t   core_video,

  // synchronised orientation mode
  input  core_pkg::orientation_e  orientation,

  // registered scaler video
  output core_pkg::scaler_video_t scaler_video
);

  localparam int hs_width = $clog2(`CORE_HS_DELAY + 1);
  localparam logic [hs_width-1:0] hs_load = hs_width'(`CORE_HS_DELAY);

  // display enable this cycle
  logic de;

  // orientation flag and slot word
  logic                       video_orientation;
  logic [`CORE_RGB_WIDTH-1:0] video_slot_rgb;

  // previous samples for edge detect
  logic de_prev;
  logic hs_prev;
  logic vs_prev;

  // hsync delay countdown
  logic [hs_width-1:0] hs_delay;

  assign de = ~(core_video.hblank | core_video.vblank);

  ////////////////////////////////////////
  // slot word
  ////////////////////////////////////////

  // auto follows the core, vertical forces the second slot
  always_comb begin
    case (orientation)
      core_pkg::orient_auto:     video_orientation = core_video.is_vertical;
      core_pkg::orient_vertical: video_orientation = 1'b1;
      default:                   video_orientation = 1'b0;
    endcase
  end

  // all zero except the orientation bit
  always_comb begin
    video_slot_rgb                 = '0;
    video_slot_rgb[`CORE_SLOT_BIT] = video_orientation;
  end

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      scaler_video <= '0;
      de_prev      <= 1'b0;
      hs_prev      <= 1'b0;
      vs_prev      <= 1'b0;
      hs_delay     <= '0;
    end else begin
      // de and pixels
      scaler_video.de <= de;
      if (de) begin
        scaler_video.rgb <= core_video.rgb;
      end else if (de_prev) begin
        // first blanked cycle carries the slot word
        scaler_video.rgb <= video_slot_rgb;
      end else begin
        scaler_video.rgb <= '0;
      end

      // hsync countdown, pulse as it reaches zero
      if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
      scaler_video.hs <= (hs_delay == hs_width'(1));
      // rising hsync restarts the delay
      if (core_video.hsync && !hs_prev) begin
        hs_delay <= hs_load;
      end

      // single cycle vs on rising vsync
      scaler_video.vs <= core_video.vsync & ~vs_prev;

      de_prev <= de;
      hs_prev <= core_video.hsync;
      vs_prev <= core_video.vsync;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_hs_single: assert property (
    @(posedge clk_74a) disable iff (reset)
      scaler_video.hs |=> !scaler_video.hs
  );

  a_vs_single: assert property (
    @(posedge clk_74a) disable iff (reset)
      scaler_video.vs |=> !scaler_video.vs
  );

endmodule

/* verilog/core_settings_top.sv */
////////////////////////////////////////
// core settings top level
// bridge register decode, settings chain
// and the scaler video formatter
////////////////////////////////////////

`timescale 1ns/1ps

`include "core_cfg.svh"

module core_settings_top (
  input  logic                        clk_74a,
  input  logic                        reset,

  // bridge bus, synchronous to clk_74a
  input  logic [`CORE_ADDR_WIDTH-1:0] bridge_addr,
  input  logic                        bridge_wr,
  input  logic [`CORE_DATA_WIDTH-1:0] bridge_wr_data,

  // video from the emulator core
  input  core_pkg::core_video_t       core_video,

  // synchronised settings for the emulator core
  output core_pkg::core_settings_t    settings,

  // video to the scaler
  output core_pkg::scaler_video_t     scaler_video
);

  // settings before the chain
  core_pkg::core_settings_t raw_settings;

  ////////////////////////////////////////
  // producer
  ////////////////////////////////////////

  bridge_settings_regs u_regs (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .raw_settings   (raw_settings)
  );

  ////////////////////////////////////////
  // buffer
  ////////////////////////////////////////

  settings_sync u_sync (
    .clk_74a      (clk_74a),
    .reset        (reset),
    .raw_settings (raw_settings),
    .settings     (settings)
  );

  ////////////////////////////////////////
  // consumer
  ////////////////////////////////////////

  // only the orientation reaches the video path
  video_output_formatter u_video (
    .clk_74a      (clk_74a),
    .reset        (reset),
    .core_video   (core_video),
    .orientation  (settings.configured_orientation),
    .scaler_video (scaler_video)
  );

endmodule

/* testbench/tb_core_settings.sv */
////////////////////////////////////////
// core settings testbench
// random bridge writes and video lines,
// checked every cycle against a model
////////////////////////////////////////

`timescale 1ns/1ps

`include "core_cfg.svh"

module tb_core_settings;

  // cycle budget per test group
  localparam int reg_test_cycles   = 700;
  localparam int hold_test_cycles  = 3 * (2 * `CORE_RESET_HOLD_CYCLES + 80);
  localparam int video_test_cycles = 2300;
  localparam int timeout_cycles    =
    2 * (16 + reg_test_cycles + hold_test_cycles + video_test_cycles);

  logic                        clk_74a;
  logic                        reset;
  logic [`CORE_ADDR_WIDTH-1:0] bridge_addr;
  logic                        bridge_wr;
  logic [`CORE_DATA_WIDTH-1:0] bridge_wr_data;
  core_pkg::core_video_t       core_video;
  core_pkg::core_settings_t    settings;
  core_pkg::scaler_video_t     scaler_video;

  // register map and some holes in it
  logic [31:0] legal_addr [14] = '{32'h0, 32'h4, 32'h8, 32'hC, 32'h10, 32'h50,
    32'h100, 32'h110, 32'h114, 32'h200, 32'h204, 32'h208, 32'h20C, 32'h300};
  logic [31:0] spare_addr [4] = '{32'h14, 32'h54, 32'h104, 32'h400};

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  core_pkg::core_settings_t m_cfg;
  // settings chain, index 2 is the output
  core_pkg::core_settings_t m_pipe [3];
  int                       m_hold;
  logic                     m_de_prev;
  logic                     m_hs_prev;
  logic                     m_vs_prev;
  // edges since the last hsync rise, -1 when idle
  int                       m_hs_age;
  core_pkg::scaler_video_t  m_video;

  // video generator state
  bit gen_active;
  bit gen_vblank;
  int gen_left;
  int cycle_count;

  core_settings_top uut (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .core_video     (core_video),
    .settings       (settings),
    .scaler_video   (scaler_video)
  );

  always #20 clk_74a = ~clk_74a;

  // hang guard
  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run("simulation ran past its cycle limit without finishing");
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic zero_model();
    m_cfg     = '0;
    m_pipe[0] = '0;
    m_pipe[1] = '0;
    m_pipe[2] = '0;
    m_hold    = 0;
    m_de_prev = 1'b0;
    m_hs_prev = 1'b0;
    m_vs_prev = 1'b0;
    m_hs_age  = -1;
    m_video   = '0;
  endtask

  // one bridge write, masked to the named fields
  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      32'h000: m_cfg.cart_download = data[0];
      32'h004: m_cfg.is_color_cart = data[0];
      32'h008: m_cfg.bw_bios_download = data[0];
      32'h00C: m_cfg.color_bios_download = data[0];
      32'h010: m_cfg.save_download = data[0];
      32'h050: m_hold = `CORE_RESET_HOLD_CYCLES;
      32'h100: m_cfg.configured_system = data[1:0];
      32'h110: m_cfg.use_cpu_turbo = data[0];
      32'h114: m_cfg.use_rewind_capture = data[0];
      32'h200: m_cfg.use_triple_buffer = data[0];
      32'h204: m_cfg.configured_flickerblend = data[1:0];
      32'h208: m_cfg.configured_orientation = core_pkg::orientation_e'(data[1:0]);
      32'h20C: m_cfg.use_flip_horizontal = data[0];
      32'h300: m_cfg.use_fastforward_sound = data[0];
      default: ;
    endcase
  endtask

  // model of one rising edge from the inputs it samples
  task automatic advance_model();
    core_pkg::core_settings_t raw;
    logic de_now;
    logic flag;
    raw                = m_cfg;
    raw.external_reset = (m_hold != 0);
    // video path sees the chain output before this edge
    de_now = !(core_video.hblank || core_video.vblank);
    if (m_pipe[2].configured_orientation == core_pkg::orient_auto) begin
      flag = core_video.is_vertical;
    end else begin
      flag = (m_pipe[2].configured_orientation == core_pkg::orient_vertical);
    end
    m_video.rgb = '0;
    if (de_now) begin
      m_video.rgb = core_video.rgb;
    end else if (m_de_prev) begin
      m_video.rgb[`CORE_SLOT_BIT] = flag;
    end
    m_video.de = de_now;
    m_video.vs = core_video.vsync && !m_vs_prev;
    // hs fires seven edges after the latest rise
    if (m_hs_age >= 0) m_hs_age++;
    m_video.hs = (m_hs_age == `CORE_HS_DELAY);
    if (core_video.hsync && !m_hs_prev) begin
      m_hs_age = 0;
    end else if (m_hs_age >= `CORE_HS_DELAY) begin
      m_hs_age = -1;
    end
    m_de_prev = de_now;
    m_hs_prev = core_video.hsync;
    m_vs_prev = core_video.vsync;
    // three stage settings delay
    m_pipe[2] = m_pipe[1];
    m_pipe[1] = m_pipe[0];
    m_pipe[0] = raw;
    if (m_hold != 0) m_hold--;
    if (bridge_wr) apply_write(bridge_addr, bridge_wr_data);
  endtask

  task automatic compare_outputs();
    check("settings", 32'(settings), 32'(m_pipe[2]));
    check("scaler_video.rgb", 32'(scaler_video.rgb), 32'(m_video.rgb));
    check("scaler_video.de", 32'(scaler_video.de), 32'(m_video.de));
    check("scaler_video.hs", 32'(scaler_video.hs), 32'(m_video.hs));
    check("scaler_video.vs", 32'(scaler_video.vs), 32'(m_video.vs));
  endtask

  // inputs stay put from the falling edge, outputs checked at the next one
  task automatic tick();
    @(posedge clk_74a);
    advance_model();
    @(negedge clk_74a);
    compare_outputs();
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    tick();
    bridge_wr      = 1'b0;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic register_sweep();
    logic [31:0] addr;
    repeat (300) begin
      if ($urandom_range(0, 4) != 0) begin
        addr = legal_addr[$urandom_range(0, 13)];
      end else if ($urandom_range(0, 1) == 1) begin
        addr = spare_addr[$urandom_range(0, 3)];
      end else begin
        addr = $urandom;
      end
      bridge_write(addr, $urandom);
      if ($urandom_range(0, 1) == 1) tick();
    end
  endtask

  // gap 0 is a single write, otherwise a second write gap edges later
  task automatic measure_reset_hold(input int gap);
    int  high_cnt;
    bit  seen;
    bit  done;
    high_cnt = 0;
    seen     = 0;
    done     = 0;
    repeat (`CORE_RESET_HOLD_CYCLES + 8) tick();
    bridge_write(32'h50, $urandom);
    for (int n = 1; n < 2 * `CORE_RESET_HOLD_CYCLES + gap; n++) begin
      if (settings.external_reset) begin
        high_cnt++;
        seen = 1;
      end else if (seen) begin
        done = 1;
        break;
      end
      if (n == gap) bridge_write(32'h50, $urandom);
      else tick();
    end
    if (!done) fail_run("external_reset hold did not finish in time");
    check("external_reset high cycles", high_cnt, gap + `CORE_RESET_HOLD_CYCLES);
  endtask

  // next input cycle of a line, reports the start of each blank run
  task automatic next_video(input int hs_div, output bit line_end);
    line_end = 0;
    if (gen_left == 0) begin
      gen_active = !gen_active;
      if (gen_active) begin
        gen_left = $urandom_range(4, 24);
      end else begin
        gen_left   = $urandom_range(2, 10);
        gen_vblank = ($urandom_range(0, 5) == 0);
        line_end   = 1;
      end
    end
    gen_left--;
    // vertical blank runs drop hblank on some cycles
    core_video.hblank      = !gen_active && (!gen_vblank || ($urandom_range(0, 1) == 1));
    core_video.vblank      = !gen_active && gen_vblank;
    core_video.hsync       = ($urandom_range(0, hs_div - 1) == 0);
    core_video.vsync       = ($urandom_range(0, 7) == 0);
    core_video.rgb         = 24'($urandom);
    core_video.is_vertical = 1'($urandom_range(0, 1));
  endtask

  // orientation rewritten at each line end
  task automatic video_frames(input int cycles, input int hs_div);
    bit line_end;
    repeat (cycles) begin
      next_video(hs_div, line_end);
      if (line_end) bridge_write(32'h208, $urandom);
      else tick();
    end
  endtask

  initial begin
    clk_74a        = 1'b0;
    reset          = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    core_video     = '0;
    cycle_count    = 0;
    gen_active     = 0;
    gen_vblank     = 0;
    gen_left       = 0;
    zero_model();
    void'($urandom(64077));
    repeat (16) @(posedge clk_74a);
    @(negedge clk_74a);
    reset = 1'b0;
    compare_outputs();
    register_sweep();
    measure_reset_hold(0);
    measure_reset_hold(20);
    measure_reset_hold(50);
    // dense hsync for restarts, then sparse for clean pulses
    video_frames(1500, 3);
    video_frames(700, 16);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
verilog/core_pkg.sv
verilog/bridge_settings_regs.sv
verilog/settings_sync.sv
verilog/video_output_formatter.sv
verilog/core_settings_top.sv
testbench/tb_core_settings.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_core_settings -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_core_settings)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation ok" || {
  echo "simulation not ok"
  exit 1
}
